//--- logic/axi_sram_params.svh
// Bus and memory widths for the AXI4 SRAM slave.
// Included by the package and by every module that sizes a vector from them.
// The SRAM holds 2**MEM_AW words of AXI_DW bits; upper address bits alias.

`ifndef AXI_SRAM_PARAMS_SVH
`define AXI_SRAM_PARAMS_SVH

// Data bus width in bits.
`define AXI_DW 64

`define AXI_AW 32 // Byte address width.
`define MEM_AW 14 // SRAM word address width.

// Byte offset bits inside one data word.
`define AXI_LSB 3

`endif

//--- logic/axi_sram_pkg.sv
// Shared types for the AXI4 SRAM slave.
// Channel payloads travel as packed structs; modules take them through
// a wildcard import in their header.

`include "axi_sram_params.svh"

package axi_sram_pkg;

	typedef enum logic [1:0] {
		burst_fixed = 2'b00, // Same address every beat.
		burst_incr  = 2'b01,
		burst_wrap  = 2'b10 // Handled as incr.
	} axi_burst_e;

	typedef enum logic [1:0] {
		resp_okay   = 2'b00,
		resp_exokay = 2'b01,
		resp_slverr = 2'b10,
		resp_decerr = 2'b11
	} axi_resp_e;

	// AW and AR share one layout.
	typedef struct packed {
		logic [`AXI_AW-1:0] addr;
		logic [7:0]         len; // Beats minus one.
		logic [2:0]         size; // Carried, always full width.
		axi_burst_e         burst;
	} axi_ax_t;

	typedef struct packed {
		logic [`AXI_DW-1:0]   data;
		logic [`AXI_DW/8-1:0] strb;
		logic                 last;
	} axi_w_t;

	typedef struct packed {
		logic [`AXI_DW-1:0] data;
		axi_resp_e          resp;
		logic               last;
	} axi_r_t;

	// One SRAM access, write when we is set.
	typedef struct packed {
		logic                 we;
		logic [`MEM_AW-1:0]   addr; // Word address.
		logic [`AXI_DW-1:0]   wdata;
		logic [`AXI_DW/8-1:0] wstrb;
	} mem_req_t;

endpackage

//--- logic/axi_burst_decode.sv
// Burst control for the AXI4 SRAM slave.
// Accepts one AW or AR at a time (AW first when both are valid), counts
// the beats, steps the word address and issues one SRAM request per beat.
// Write beats go to the SRAM on their W transfer; read beats are issued
// whenever the response stage has room for the returned word.

`timescale 1ns/100ps
`include "axi_sram_params.svh"

module axi_burst_decode import axi_sram_pkg::*; (
	input  logic     CLK,
	input  logic     arst_n,
	input  axi_ax_t  aw,
	input  logic     aw_valid,
	output logic     aw_ready,
	input  axi_w_t   w,
	input  logic     w_valid,
	output logic     w_ready,
	input  axi_ax_t  ar,
	input  logic     ar_valid,
	output logic     ar_ready,
	output logic     wr_done,
	input  logic     b_done,
	output logic     rd_issue,
	output logic     rd_last,
	input  logic     rd_slot_free,
	input  logic     r_done,
	output mem_req_t mem_req,
	output logic     mem_en
);

	typedef enum logic [2:0] {
		st_idle,
		st_write,
		st_wr_resp,
		st_read,
		st_rd_drain
	} state_e;

	state_e             state;
	state_e             state_nxt;
	axi_ax_t            ax_sel;
	axi_burst_e         burst_q;
	logic [7:0]         len_q;
	logic [7:0]         beat_cnt;
	logic [`MEM_AW-1:0] addr_q;
	logic [`MEM_AW-1:0] addr_step;
	logic               ax_fire;
	logic               w_fire;
	logic               beat_end;

	assign aw_ready = (state == st_idle) & aw_valid;
	assign ar_ready = (state == st_idle) & ar_valid & ~aw_valid; // AW has priority.
	assign ax_fire  = aw_ready | ar_ready;
	assign ax_sel   = aw_valid ? aw : ar;

	assign w_ready  = (state == st_write);
	assign w_fire   = w_ready & w_valid;
	assign rd_issue = (state == st_read) & rd_slot_free;

	// Burst ends on the beat count, w.last is not looked at.
	assign beat_end = (beat_cnt == len_q);
	assign wr_done  = w_fire & beat_end;
	assign rd_last  = rd_issue & beat_end;

	assign addr_step = (burst_q == burst_fixed) ? addr_q : addr_q + 1'b1; // Wrap as incr.

	assign mem_en  = w_fire | rd_issue;
	assign mem_req = '{we: w_ready, addr: addr_q, wdata: w.data, wstrb: w.strb};

	always_comb begin
		state_nxt = state;
		case (state)
			st_idle: begin
				if (aw_ready)
					state_nxt = st_write;
				else if (ar_ready)
					state_nxt = st_read;
			end
			st_write:    if (wr_done) state_nxt = st_wr_resp;
			st_wr_resp:  if (b_done) state_nxt = st_idle;
			st_read:     if (rd_last) state_nxt = st_rd_drain; // Wait for the R side.
			st_rd_drain: if (r_done) state_nxt = st_idle;
			default:     state_nxt = st_idle;
		endcase
	end

	always_ff @(posedge CLK or negedge arst_n) begin
		if (!arst_n) begin
			state    <= st_idle;
			beat_cnt <= '0;
		end else begin
			state <= state_nxt;
			if (ax_fire)
				beat_cnt <= '0;
			else if (mem_en)
				beat_cnt <= beat_cnt + 8'd1; // One per W beat or read issue.
		end
	end

	// Burst parameters, captured on the accepting edge.
	always_ff @(posedge CLK) begin
		if (ax_fire) begin
			burst_q <= ax_sel.burst;
			len_q   <= ax_sel.len;
			addr_q  <= ax_sel.addr[`AXI_LSB +: `MEM_AW]; // Upper bits alias.
		end else if (mem_en) begin
			addr_q <= addr_step;
		end
	end

endmodule

//--- logic/sram_bank.sv
// Single-port SRAM behind the AXI4 slave.
// A write updates only the byte lanes whose strobe is set; a read
// returns the addressed word on rd_data one cycle later.
// rd_data keeps its value until the next read, so the response stage
// can use it as the R data register.

`timescale 1ns/100ps
`include "axi_sram_params.svh"

module sram_bank import axi_sram_pkg::*; (
	input  logic               CLK,
	input  mem_req_t           mem_req,
	input  logic               mem_en,
	output logic [`AXI_DW-1:0] rd_data
);

	localparam int unsigned DEPTH = 1 << `MEM_AW;
	localparam int unsigned LANES = `AXI_DW / 8;

	logic [`AXI_DW-1:0] mem [0:DEPTH-1];

	// Byte-lane writes.
	always_ff @(posedge CLK) begin
		if (mem_en && mem_req.we) begin
			for (int unsigned i = 0; i < LANES; i++) begin
				if (mem_req.wstrb[i])
					mem[mem_req.addr][i*8 +: 8] <= mem_req.wdata[i*8 +: 8];
			end
		end
	end

	// Registered read port, held between reads.
	always_ff @(posedge CLK) begin
		if (mem_en && !mem_req.we)
			rd_data <= mem[mem_req.addr];
	end

endmodule

//--- logic/axi_resp_gen.sv
// Response side of the AXI4 SRAM slave.
// Raises b_valid the cycle after the last W beat and holds it until
// b_ready. For reads, r_valid rises the cycle after each issue, when the
// SRAM read register carries the word; the word stays there until the
// beat is taken because decode only issues while the slot is free.
// Also returns the B and final-R completion pulses to decode.

`timescale 1ns/100ps
`include "axi_sram_params.svh"

module axi_resp_gen import axi_sram_pkg::*; (
	input  logic               CLK,
	input  logic               arst_n,
	input  logic               wr_done,
	output logic               b_valid,
	input  logic               b_ready,
	output axi_resp_e          b_resp,
	input  logic               rd_issue,
	input  logic               rd_last,
	input  logic [`AXI_DW-1:0] rd_data,
	output axi_r_t             r,
	output logic               r_valid,
	input  logic               r_ready,
	output logic               rd_slot_free,
	output logic               b_done,
	output logic               r_done
);

	logic last_pend; // rd_last, one cycle late to match rd_data.

	assign b_resp = resp_okay;
	assign b_done = b_valid & b_ready;

	always_ff @(posedge CLK or negedge arst_n) begin
		if (!arst_n)
			b_valid <= 1'b0;
		else if (wr_done)
			b_valid <= 1'b1;
		else if (b_done)
			b_valid <= 1'b0;
	end

	// Read data only lands on the edge after an issue, and that edge also
	// raises r_valid, so a taken beat is enough to free the slot.
	assign rd_slot_free = ~r_valid | r_ready;

	assign r_done = r_valid & r_ready & last_pend;
	assign r      = '{data: rd_data, resp: resp_okay, last: last_pend};

	always_ff @(posedge CLK or negedge arst_n) begin
		if (!arst_n) begin
			r_valid   <= 1'b0;
			last_pend <= 1'b0;
		end else begin
			if (rd_issue) begin
				r_valid   <= 1'b1; // Refill, even while the old beat leaves.
				last_pend <= rd_last;
			end else if (r_valid && r_ready) begin
				r_valid   <= 1'b0;
				last_pend <= 1'b0;
			end
		end
	end

endmodule

//--- logic/axi_sram_top.sv
// AXI4 slave with an on-chip SRAM, one burst at a time.
// Burst decode drives the SRAM, the response stage builds B and R.
// Connect the five AXI channels; CLK and arst_n are shared by all parts.

`timescale 1ns/100ps
`include "axi_sram_params.svh"

module axi_sram_top import axi_sram_pkg::*; (
	input  logic      CLK,
	input  logic      arst_n,
	input  axi_ax_t   aw,
	input  logic      aw_valid,
	output logic      aw_ready,
	input  axi_w_t    w,
	input  logic      w_valid,
	output logic      w_ready,
	output axi_resp_e b_resp,
	output logic      b_valid,
	input  logic      b_ready,
	input  axi_ax_t   ar,
	input  logic      ar_valid,
	output logic      ar_ready,
	output axi_r_t    r,
	output logic      r_valid,
	input  logic      r_ready
);

	mem_req_t           mem_req;
	logic               mem_en;
	logic [`AXI_DW-1:0] rd_data; // SRAM read register.
	logic               rd_issue;
	logic               rd_last;
	logic               rd_slot_free;
	logic               wr_done;
	logic               b_done;
	logic               r_done;

	axi_burst_decode u_decode (
		.CLK          (CLK),
		.arst_n       (arst_n),
		.aw           (aw),
		.aw_valid     (aw_valid),
		.aw_ready     (aw_ready),
		.w            (w),
		.w_valid      (w_valid),
		.w_ready      (w_ready),
		.ar           (ar),
		.ar_valid     (ar_valid),
		.ar_ready     (ar_ready),
		.wr_done      (wr_done),
		.b_done       (b_done),
		.rd_issue     (rd_issue),
		.rd_last      (rd_last),
		.rd_slot_free (rd_slot_free),
		.r_done       (r_done),
		.mem_req      (mem_req),
		.mem_en       (mem_en)
	);

	sram_bank u_sram (
		.CLK     (CLK),
		.mem_req (mem_req),
		.mem_en  (mem_en),
		.rd_data (rd_data)
	);

	axi_resp_gen u_resp (
		.CLK          (CLK),
		.arst_n       (arst_n),
		.wr_done      (wr_done),
		.b_valid      (b_valid),
		.b_ready      (b_ready),
		.b_resp       (b_resp),
		.rd_issue     (rd_issue),
		.rd_last      (rd_last),
		.rd_data      (rd_data),
		.r            (r),
		.r_valid      (r_valid),
		.r_ready      (r_ready),
		.rd_slot_free (rd_slot_free),
		.b_done       (b_done),
		.r_done       (r_done)
	);

endmodule

//--- dv/axi_sram_checker.sv
// Protocol assertions for the AXI4 SRAM slave.
// Bound to every instance of the top level; reports through $error only.

`timescale 1ns/100ps

module axi_sram_checker import axi_sram_pkg::*; (
	input logic   CLK,
	input logic   arst_n,
	input logic   aw_ready,
	input logic   ar_ready,
	input logic   w_ready,
	input logic   b_valid,
	input logic   b_ready,
	input axi_r_t r,
	input logic   r_valid,
	input logic   r_ready
);

	b_hold: assert property (@(posedge CLK) disable iff (!arst_n)
		b_valid && !b_ready |=> b_valid)
		else $error("b_valid dropped before b_ready");

	r_hold: assert property (@(posedge CLK) disable iff (!arst_n)
		r_valid && !r_ready |=> r_valid && $stable(r))
		else $error("R beat changed before r_ready");

	ax_excl: assert property (@(posedge CLK) disable iff (!arst_n)
		!(aw_ready && ar_ready))
		else $error("aw_ready and ar_ready high together");

	w_r_excl: assert property (@(posedge CLK) disable iff (!arst_n)
		!(w_ready && r_valid))
		else $error("w_ready high while r_valid is high");

endmodule

bind axi_sram_top axi_sram_checker u_checker (.*);

//--- dv/axi_sram_tb.sv
// Testbench for the AXI4 SRAM slave.
// Runs reset, single-beat, INCR, FIXED, back-pressure and arbitration
// cases against a byte-level model memory; R and B are checked at negedge.

`timescale 1ns/100ps
`include "axi_sram_params.svh"

module axi_sram_tb import axi_sram_pkg::*; ();

	localparam int TMO   = 2000; // Cycle limit of each wait.
	localparam int WMASK = (1 << `MEM_AW) - 1;

	logic      CLK;
	logic      arst_n;
	axi_ax_t   aw;
	logic      aw_valid;
	logic      aw_ready;
	axi_w_t    w;
	logic      w_valid;
	logic      w_ready;
	axi_resp_e b_resp;
	logic      b_valid;
	logic      b_ready;
	axi_ax_t   ar;
	logic      ar_valid;
	logic      ar_ready;
	axi_r_t    r;
	logic      r_valid;
	logic      r_ready;

	integer     seed = 32'h6bd5;
	logic       bp_on = 1'b0; // Random back-pressure enable.
	int         b_count = 0;
	int         b_exp = 0; // B responses owed so far.
	int         r_count = 0;
	logic [7:0] model_mem [int]; // Keyed by word index * 8 + lane.
	axi_r_t     exp_q [$];

	axi_sram_top DUT (.*);

	initial begin
		CLK = 1'b0;
		forever #5 CLK = ~CLK;
	end

	task automatic abort_run(input string msg);
		$display("%s", msg);
		$display("TESTBENCH FAILED");
		$fatal(1);
	endtask

	task automatic check_r(input axi_r_t got, input axi_r_t exp);
		if (got !== exp) begin
			$display("FAIL r: data %h resp %h last %h, expected data %h resp %h last %h",
				got.data, got.resp, got.last, exp.data, exp.resp, exp.last);
			abort_run("Read beat mismatch.");
		end
	endtask

	task automatic check_b(input axi_resp_e got, input axi_resp_e exp);
		if (got !== exp) begin
			$display("FAIL b_resp: got %h expected %h", got, exp);
			abort_run("Write response mismatch.");
		end
	endtask

	task automatic check_low(input string name, input logic got);
		if (got !== 1'b0) begin
			$display("FAIL %s: got %h expected 0", name, got);
			abort_run("Output high while idle.");
		end
	endtask

	// Word index of beat i, following the burst rule and memory aliasing.
	function automatic int word_index(input logic [31:0] addr, input axi_burst_e burst,
		input int i);
		int base;
		base = int'(addr >> `AXI_LSB);
		if (burst == burst_fixed)
			return base & WMASK;
		return (base + i) & WMASK; // Wrap acts as incr.
	endfunction

	function automatic logic [63:0] ref_word(input int widx);
		logic [63:0] word;
		for (int l = 0; l < 8; l++)
			word[l*8 +: 8] = model_mem.exists(widx*8 + l) ? model_mem[widx*8 + l] : 8'hxx;
		return word;
	endfunction

	// Compare process.
	always @(negedge CLK) begin
		if (r_valid && r_ready) begin
			if (exp_q.size() == 0)
				abort_run("An R beat arrived when no beat was expected.");
			check_r(r, exp_q.pop_front());
			r_count++;
		end
		if (b_valid && b_ready) begin
			if (b_count >= b_exp)
				abort_run("A B response arrived when none was expected.");
			check_b(b_resp, resp_okay);
			b_count++;
		end
	end

	always @(posedge CLK) begin
		#1;
		b_ready = bp_on ? ($random(seed) & 1) : 1'b1;
		r_ready = bp_on ? (($random(seed) & 3) != 0) : 1'b1;
	end

	task automatic write_burst(input logic [31:0] addr, input logic [7:0] len,
		input axi_burst_e burst, input logic full_strb);
		int cnt;
		int widx;
		int start_b;
		start_b = b_count;
		b_exp++;
		aw = '{addr: addr, len: len, size: 3'd3, burst: burst};
		aw_valid = 1'b1;
		cnt = 0;
		@(negedge CLK);
		while (!aw_ready) begin
			if (++cnt > TMO) abort_run("Timeout waiting for aw_ready.");
			@(negedge CLK);
		end
		@(posedge CLK) #1;
		aw_valid = 1'b0;
		for (int i = 0; i <= len; i++) begin
			while (bp_on && ($random(seed) & 1)) begin
				w_valid = 1'b0; // Idle W cycle.
				@(posedge CLK) #1;
			end
			w.data = {$random(seed), $random(seed)};
			w.strb = full_strb ? 8'hff : $random(seed);
			w.last = (i == len);
			w_valid = 1'b1;
			widx = word_index(addr, burst, i);
			for (int l = 0; l < 8; l++)
				if (w.strb[l])
					model_mem[widx*8 + l] = w.data[l*8 +: 8];
			cnt = 0;
			@(negedge CLK);
			while (!w_ready) begin
				if (++cnt > TMO) abort_run("Timeout waiting for w_ready.");
				@(negedge CLK);
			end
			@(posedge CLK) #1;
		end
		w_valid = 1'b0;
		cnt = 0;
		while (b_count == start_b) begin
			if (++cnt > TMO) abort_run("Timeout waiting for the write response.");
			@(posedge CLK) #1;
		end
	endtask

	task automatic read_burst(input logic [31:0] addr, input logic [7:0] len,
		input axi_burst_e burst);
		int cnt;
		int start_r;
		for (int i = 0; i <= len; i++)
			exp_q.push_back('{data: ref_word(word_index(addr, burst, i)),
				resp: resp_okay, last: (i == len)});
		start_r = r_count;
		ar = '{addr: addr, len: len, size: 3'd3, burst: burst};
		ar_valid = 1'b1;
		cnt = 0;
		@(negedge CLK);
		while (!ar_ready) begin
			if (++cnt > TMO) abort_run("Timeout waiting for ar_ready.");
			@(negedge CLK);
		end
		@(posedge CLK) #1;
		ar_valid = 1'b0;
		cnt = 0;
		while (r_count < start_r + len + 1) begin
			if (++cnt > TMO) abort_run("Timeout waiting for read beats.");
			@(posedge CLK) #1;
		end
		repeat (3) @(posedge CLK); // Catch any extra beat.
		#1;
		check_idle();
	endtask

	task automatic check_idle();
		check_low("aw_ready", aw_ready);
		check_low("w_ready", w_ready);
		check_low("ar_ready", ar_ready);
		check_low("b_valid", b_valid);
		check_low("r_valid", r_valid);
	endtask

	initial begin
		arst_n   = 1'b0;
		aw       = '0;
		aw_valid = 1'b0;
		w        = '0;
		w_valid  = 1'b0;
		ar       = '0;
		ar_valid = 1'b0;
		b_ready  = 1'b0;
		r_ready  = 1'b0;
		repeat (16) begin
			@(negedge CLK);
			check_idle();
		end
		@(posedge CLK) #1;
		arst_n = 1'b1;
		repeat (3) begin
			@(negedge CLK);
			check_idle();
		end
		@(posedge CLK) #1;
		write_burst(32'h100, 8'd0, burst_incr, 1'b1);
		read_burst(32'h100, 8'd0, burst_incr);
		write_burst(32'h2000, 8'd15, burst_incr, 1'b0);
		read_burst(32'h2000, 8'd15, burst_incr);
		write_burst(32'h4008, 8'd7, burst_fixed, 1'b0);
		read_burst(32'h4008, 8'd3, burst_fixed);
		bp_on = 1'b1;
		write_burst(32'h3fff0, 8'd31, burst_incr, 1'b0); // Crosses the alias boundary.
		read_burst(32'h3fff0, 8'd31, burst_wrap);
		read_burst(32'h4008, 8'd5, burst_fixed);
		bp_on = 1'b0;
		ar = '{addr: 32'h600, len: 8'd3, size: 3'd3, burst: burst_incr};
		ar_valid = 1'b1; // Raised with aw_valid in the same cycle.
		write_burst(32'h600, 8'd3, burst_incr, 1'b1);
		read_burst(32'h600, 8'd3, burst_incr);
		$display("TESTBENCH PASSED");
		$finish;
	end

endmodule

//--- src.f
+incdir+logic
logic/axi_sram_pkg.sv
logic/axi_burst_decode.sv
logic/sram_bank.sv
logic/axi_resp_gen.sv
logic/axi_sram_top.sv
dv/axi_sram_checker.sv
dv/axi_sram_tb.sv
